//--- kv_top.f
common/kv_defines_pkg.sv
hdl/kv_write_rule_check.sv
hdl/kv_write_port.sv
kv_store/kv_slot_store.sv
hdl/kv_top.sv
test/kv_tb_clk.sv
test/kv_top_chk.sv
test/kv_top_tb.sv

//--- test/kv_top_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault write path testbench
// Table-driven writes checked against a slot model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_top_tb
    import kv_defines_pkg::*;
();

    localparam int DATA_W   = 32;
    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 20;
    localparam int SRC_AES  = 1 << KV_WRITE_IDX_AES;
    localparam int SRC_HMAC = 1 << KV_WRITE_IDX_HMAC;
    localparam int SRC_SHA  = 1 << KV_WRITE_IDX_SHA;
    localparam int SRC_ECC  = 1 << KV_WRITE_IDX_ECC;

    // One table row is the lock level, the request and the expected error flag
    typedef struct packed {
        logic          lock;
        kv_write_req_t info;
        logic          exp_err;
    } row_t;

    logic                  clk;
    logic                  rst_b;
    logic                  ocp_lock_in_progress;
    logic                  write_req;
    kv_write_req_t         write_info;
    logic [DATA_W-1:0]     write_data;
    logic                  clear;
    logic [KV_ENTRY_W-1:0] rd_entry;
    logic                  busy;
    logic                  write_done;
    logic                  write_error;
    logic [DATA_W-1:0]     rd_data;

    row_t              table_rows [NUM_ROWS];
    logic [DATA_W-1:0] model [KV_NUM_SLOTS];
    logic [31:0]       lfsr;
    int                mismatches;
    int                timeouts;

    kv_tb_clk kv_tb_clk_inst (
        .clk  (clk),
        .rst_b(rst_b)
    );

    kv_top #(
        .DATA_W(DATA_W)
    ) kv_top_inst (
        .clk                 (clk),
        .rst_b               (rst_b),
        .ocp_lock_in_progress(ocp_lock_in_progress),
        .write_req           (write_req),
        .write_info          (write_info),
        .write_data          (write_data),
        .clear               (clear),
        .rd_entry            (rd_entry),
        .busy                (busy),
        .write_done          (write_done),
        .write_error         (write_error),
        .rd_data             (rd_data)
    );

    function automatic row_t make_row(input int lock, input int src, input int entry,
                                      input int d0p, input int d0e, input int d1p,
                                      input int d1e, input int ecb, input int err);
        row_t r;
        r.lock                    = 1'(lock);
        r.info.kv_write_src       = KV_NUM_WRITE'(src);
        r.info.kv_write_entry     = KV_ENTRY_W'(entry);
        r.info.kv_data0_present   = 1'(d0p);
        r.info.kv_data0_entry     = KV_ENTRY_W'(d0e);
        r.info.kv_data1_present   = 1'(d1p);
        r.info.kv_data1_entry     = KV_ENTRY_W'(d1e);
        r.info.aes_decrypt_ecb_op = 1'(ecb);
        r.exp_err                 = 1'(err);
        return r;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per data bit
    task automatic next_word(output logic [DATA_W-1:0] w);
        for (int i = 0; i < DATA_W; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    task automatic check_error(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] act,
                              input logic [DATA_W-1:0] exp);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    // Waits for busy to drop when idle is set, otherwise for the write_done pulse
    task automatic wait_for(input logic idle, input string what, output logic ok);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge clk);
            ok = idle ? !busy : write_done;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    // The read port is registered, so data is sampled one cycle after the address
    task automatic read_slot(input int e, output logic [DATA_W-1:0] d);
        @(posedge clk);
        rd_entry <= KV_ENTRY_W'(e);
        @(posedge clk);
        @(negedge clk);
        d = rd_data;
    endtask

    // Reads the whole index space, entries past the vault must read zero
    task automatic sweep_slots();
        logic [DATA_W-1:0] d;
        for (int e = 0; e < 32; e++) begin
            read_slot(e, d);
            check_data($sformatf("rd_data[%0d]", e), d,
                       (e < KV_NUM_SLOTS) ? model[e] : {DATA_W{1'b0}});
        end
    endtask

    task automatic run_row(input int r, output logic ok);
        row_t              row;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] d;
        row = table_rows[r];
        next_word(data);
        wait_for(1'b1, "busy to drop", ok);
        if (!ok) return;
        @(posedge clk);
        ocp_lock_in_progress <= row.lock;
        write_info           <= row.info;
        write_data           <= data;
        write_req            <= 1'b1;
        @(posedge clk);
        write_req <= 1'b0;
        // busy holds from the accepting edge until the completion pulse
        @(negedge clk);
        check_error($sformatf("busy row %0d", r), busy, 1'b1);
        wait_for(1'b0, $sformatf("write_done of row %0d", r), ok);
        if (!ok) return;
        check_error($sformatf("write_error row %0d", r), write_error, row.exp_err);
        check_error($sformatf("busy at done row %0d", r), busy, 1'b0);
        // Only an allowed write changes the slot
        if (!row.exp_err) begin
            model[row.info.kv_write_entry] = data;
        end
        read_slot(row.info.kv_write_entry, d);
        check_data($sformatf("rd_data row %0d", r), d, model[row.info.kv_write_entry]);
    endtask

    initial begin
        logic ok;
        int   total;
        ocp_lock_in_progress = 1'b0;
        write_req            = 1'b0;
        write_info           = '0;
        write_data           = '0;
        clear                = 1'b0;
        rd_entry             = '0;
        lfsr                 = 32'd70336;
        mismatches           = 0;
        timeouts             = 0;
        for (int i = 0; i < KV_NUM_SLOTS; i++) begin
            model[i] = '0;
        end

        // No lock, so only the AES rule applies
        table_rows[0]  = make_row(0, SRC_HMAC, 3, 0, 0, 0, 0, 0, 0);
        table_rows[1]  = make_row(0, SRC_SHA, 20, 1, 5, 0, 0, 0, 0);
        table_rows[2]  = make_row(0, SRC_ECC, 23, 1, 17, 1, 2, 0, 0);
        table_rows[3]  = make_row(0, SRC_AES, 23, 1, 16, 0, 0, 1, 1);
        // Key-release slot under lock
        table_rows[4]  = make_row(1, SRC_HMAC, 23, 0, 0, 0, 0, 0, 1);
        table_rows[5]  = make_row(1, SRC_AES, 23, 1, 16, 0, 0, 1, 0);
        // AES missing one condition each
        table_rows[6]  = make_row(1, SRC_AES, 22, 1, 16, 0, 0, 1, 1);
        table_rows[7]  = make_row(1, SRC_AES, 23, 1, 16, 0, 0, 0, 1);
        table_rows[8]  = make_row(1, SRC_AES, 23, 0, 16, 0, 0, 1, 1);
        table_rows[9]  = make_row(1, SRC_AES, 23, 1, 17, 0, 0, 1, 1);
        // Region crossing, data1 included, absent sources ignored
        table_rows[10] = make_row(1, SRC_SHA, 18, 1, 4, 0, 0, 0, 1);
        table_rows[11] = make_row(1, SRC_HMAC, 7, 1, 19, 0, 0, 0, 1);
        table_rows[12] = make_row(1, SRC_ECC, 9, 1, 2, 1, 20, 0, 1);
        table_rows[13] = make_row(1, SRC_ECC, 21, 1, 17, 1, 3, 0, 1);
        table_rows[14] = make_row(1, SRC_SHA, 11, 0, 20, 1, 5, 0, 0);
        table_rows[15] = make_row(1, SRC_HMAC, 19, 1, 18, 0, 6, 0, 0);

        ok = 1'b0;
        for (int n = 0; n < 40 && !ok; n++) begin
            @(negedge clk);
            ok = rst_b;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end else begin
            check_error("busy", busy, 1'b0);
            check_error("write_done", write_done, 1'b0);
            check_error("write_error", write_error, 1'b0);
            sweep_slots();
            for (int r = 0; r < NUM_ROWS && ok; r++) begin
                run_row(r, ok);
            end
            if (ok) begin
                sweep_slots();
                @(posedge clk);
                clear <= 1'b1;
                @(posedge clk);
                clear <= 1'b0;
                for (int i = 0; i < KV_NUM_SLOTS; i++) begin
                    model[i] = '0;
                end
                sweep_slots();
            end
        end

        total = mismatches + timeouts + kv_top_inst.kv_top_chk_inst.assert_fails;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, kv_top_inst.kv_top_chk_inst.assert_fails);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- test/kv_top_chk.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault write path checker
// Completion timing and commit gating assertions
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_top_chk (
    input logic clk,
    input logic rst_b,
    input logic write_req,
    input logic busy,
    input logic write_done,
    input logic write_error,
    input logic store_we
);

    // Running count of failed assertions
    int assert_fails = 0;

    // Completion is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst_b)
        write_done |=> !write_done)
        else begin
            assert_fails++;
            $error("write_done stayed high for more than one cycle");
        end

    // A request sampled at edge 0 completes after edge 2, so the pulse is seen at edge 3
    done_latency: assert property (@(posedge clk) disable iff (!rst_b)
        (write_req && !busy) |-> ##3 write_done)
        else begin
            assert_fails++;
            $error("write_done did not follow an accepted request by two cycles");
        end

    // A commit into the store is always reported as a completion without error
    commit_gated: assert property (@(posedge clk) disable iff (!rst_b)
        store_we |=> (write_done && !write_error))
        else begin
            assert_fails++;
            $error("store_we committed a write that did not complete without error");
        end

endmodule

bind kv_top kv_top_chk kv_top_chk_inst (.*);

//--- test/kv_tb_clk.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_tb_clk (
    output logic clk,
    output logic rst_b
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is held low for 16 rising edges and released on an edge
    initial begin
        rst_b = 1'b0;
        repeat (16) @(posedge clk);
        rst_b <= 1'b1;
    end

endmodule

//--- hdl/kv_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault write path top
// Joins the write port, rule checker and slot store
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_top
    import kv_defines_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  ocp_lock_in_progress,
    input  logic                  write_req,
    input  var kv_write_req_t     write_info,
    input  logic [DATA_W-1:0]     write_data,
    input  logic                  clear,
    input  logic [KV_ENTRY_W-1:0] rd_entry,
    output logic                  busy,
    output logic                  write_done,
    output logic                  write_error,
    output logic [DATA_W-1:0]     rd_data
);

    kv_write_filter_metrics_t metrics;
    logic                     write_allow;
    logic                     store_we;
    logic [KV_ENTRY_W-1:0]    store_entry;
    logic [DATA_W-1:0]        store_data;

    // Request handling and commit sequencing
    kv_write_port #(
        .DATA_W(DATA_W)
    ) kv_write_port_inst (
        .clk                 (clk),
        .rst_b               (rst_b),
        .ocp_lock_in_progress(ocp_lock_in_progress),
        .write_req           (write_req),
        .write_info          (write_info),
        .write_data          (write_data),
        .write_allow         (write_allow),
        .metrics             (metrics),
        .store_we            (store_we),
        .store_entry         (store_entry),
        .store_data          (store_data),
        .busy                (busy),
        .write_done          (write_done),
        .write_error         (write_error)
    );

    // Verdict on the latched request, one cycle behind the metrics
    kv_write_rule_check kv_write_rule_check_inst (
        .clk          (clk),
        .rst_b        (rst_b),
        .write_metrics(metrics),
        .write_allow  (write_allow)
    );

    kv_slot_store #(
        .DATA_W(DATA_W)
    ) kv_slot_store_inst (
        .clk        (clk),
        .rst_b      (rst_b),
        .store_we   (store_we),
        .store_entry(store_entry),
        .store_data (store_data),
        .clear      (clear),
        .rd_entry   (rd_entry),
        .rd_data    (rd_data)
    );

endmodule

//--- kv_store/kv_slot_store.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault slot store
// Slot array with one write port, a registered read and a clear
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_slot_store
    import kv_defines_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  store_we,
    input  logic [KV_ENTRY_W-1:0] store_entry,
    input  logic [DATA_W-1:0]     store_data,
    input  logic                  clear,
    input  logic [KV_ENTRY_W-1:0] rd_entry,
    output logic [DATA_W-1:0]     rd_data
);

    logic [DATA_W-1:0] slots [KV_NUM_SLOTS];
    logic              wr_in_range;
    logic              rd_in_range;

    // The index space is wider than the vault, so the top entries do not exist
    assign wr_in_range = (store_entry < KV_NUM_SLOTS);
    assign rd_in_range = (rd_entry < KV_NUM_SLOTS);

    // Key material must not survive reset
    // Clear wins over a commit on the same edge
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < KV_NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < KV_NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else if (store_we && wr_in_range) begin
            slots[store_entry] <= store_data;
        end
    end

    // Registered read, entries past the vault read as zero
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_data <= '0;
        end else if (rd_in_range) begin
            rd_data <= slots[rd_entry];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- hdl/kv_write_port.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault write port
// Latches a request, waits for the rule verdict, then commits
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_write_port
    import kv_defines_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic                          clk,
    input  logic                          rst_b,
    input  logic                          ocp_lock_in_progress,
    input  logic                          write_req,
    input  var kv_write_req_t             write_info,
    input  logic [DATA_W-1:0]             write_data,
    input  logic                          write_allow,
    output kv_write_filter_metrics_t      metrics,
    output logic                          store_we,
    output logic [KV_ENTRY_W-1:0]         store_entry,
    output logic [DATA_W-1:0]             store_data,
    output logic                          busy,
    output logic                          write_done,
    output logic                          write_error
);

    // Idle waits for a request, check lets the verdict settle, commit acts on it
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_COMMIT
    } port_state_e;

    port_state_e       state;
    port_state_e       state_nxt;
    logic              accept;
    logic [DATA_W-1:0] data_q;

    // Requests that arrive while busy are dropped
    assign accept = write_req && (state == ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (accept) state_nxt = ST_CHECK;
            ST_CHECK:  state_nxt = ST_COMMIT;
            ST_COMMIT: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // The lock level is sampled together with the request fields
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            metrics <= '0;
        end else if (accept) begin
            metrics.ocp_lock_in_progress <= ocp_lock_in_progress;
            metrics.kv_write_src         <= write_info.kv_write_src;
            metrics.kv_write_entry       <= write_info.kv_write_entry;
            metrics.kv_data0_present     <= write_info.kv_data0_present;
            metrics.kv_data0_entry       <= write_info.kv_data0_entry;
            metrics.kv_data1_present     <= write_info.kv_data1_present;
            metrics.kv_data1_entry       <= write_info.kv_data1_entry;
            metrics.aes_decrypt_ecb_op   <= write_info.aes_decrypt_ecb_op;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= write_data;
        end
    end

    // write_allow is valid during the commit cycle, so the store writes on the next edge
    assign store_we    = (state == ST_COMMIT) && write_allow;
    assign store_entry = metrics.kv_write_entry;
    assign store_data  = data_q;
    assign busy        = (state != ST_IDLE);

    // Completion pulse, with the error flag valid alongside it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            write_done  <= 1'b0;
            write_error <= 1'b0;
        end else begin
            write_done  <= (state == ST_COMMIT);
            write_error <= (state == ST_COMMIT) && !write_allow;
        end
    end

endmodule

//--- hdl/kv_write_rule_check.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault write rule checker
// Evaluates the OCP lock write rules and registers the verdict
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module kv_write_rule_check
    import kv_defines_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_b,
    input  var kv_write_filter_metrics_t write_metrics,
    output logic                         write_allow
);

    // One bit per rule, set when that rule is violated
    typedef struct packed {
        logic release_not_aes;
        logic std_src_escapes;
        logic lock_src_escapes;
        logic aes_bad_use;
    } rule_fail_t;

    rule_fail_t fail;
    logic       lock;
    logic       any_std_src;
    logic       any_lock_src;
    logic       non_aes_src;

    assign lock = write_metrics.ocp_lock_in_progress;

    // Any engine other than AES is named in the one-hot source field
    assign non_aes_src = |(write_metrics.kv_write_src &
                           ~(KV_NUM_WRITE'(1) << KV_WRITE_IDX_AES));

    // Source keys only count when their present bit is set
    always_comb begin
        any_std_src  = (write_metrics.kv_data0_present &&
                        kv_in_std_region(write_metrics.kv_data0_entry)) ||
                       (write_metrics.kv_data1_present &&
                        kv_in_std_region(write_metrics.kv_data1_entry));
        any_lock_src = (write_metrics.kv_data0_present &&
                        kv_in_lock_region(write_metrics.kv_data0_entry)) ||
                       (write_metrics.kv_data1_present &&
                        kv_in_lock_region(write_metrics.kv_data1_entry));
    end

    always_comb begin
        // Under lock the key-release slot is reserved for AES
        fail.release_not_aes = lock && non_aes_src &&
                               (write_metrics.kv_write_entry == OCP_LOCK_KEY_RELEASE_KV_SLOT);

        // Under lock a standard key may not leave the standard region
        fail.std_src_escapes = lock && any_std_src &&
                               !kv_in_std_region(write_metrics.kv_write_entry);

        // Under lock a lock-region key may not leave the lock region
        fail.lock_src_escapes = lock && any_lock_src &&
                                !kv_in_lock_region(write_metrics.kv_write_entry);

        // AES may only write the vault for the key-release decrypt
        // Every condition must hold, so missing any one of them fails the rule
        fail.aes_bad_use = write_metrics.kv_write_src[KV_WRITE_IDX_AES] &&
                           (!lock ||
                            !write_metrics.aes_decrypt_ecb_op ||
                            !write_metrics.kv_data0_present ||
                            (write_metrics.kv_data0_entry != OCP_LOCK_RT_OBF_KEY_KV_SLOT) ||
                            (write_metrics.kv_write_entry != OCP_LOCK_KEY_RELEASE_KV_SLOT));
    end

    // The verdict is registered so the port sees it one cycle after the metrics
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            write_allow <= 1'b0;
        end else begin
            write_allow <= ~|fail;
        end
    end

endmodule

//--- common/kv_defines_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Key vault shared definitions
// Slot map, write sources, request and rule metrics
// ~~~~~~~~~~~~~~~~~~~~
package kv_defines_pkg;

    // Number of key vault slots and the width of an index into them
    localparam int KV_NUM_SLOTS = 24;
    localparam int KV_ENTRY_W   = 5;

    // Standard slots sit at the bottom of the vault
    localparam logic [KV_ENTRY_W-1:0] KV_STANDARD_SLOT_LOW = 5'd0;
    localparam logic [KV_ENTRY_W-1:0] KV_STANDARD_SLOT_HI  = 5'd15;

    // The upper eight slots are reserved for the OCP lock flow
    localparam logic [KV_ENTRY_W-1:0] KV_OCP_LOCK_SLOT_LOW = 5'd16;
    localparam logic [KV_ENTRY_W-1:0] KV_OCP_LOCK_SLOT_HI  = 5'd23;

    // Fixed slots inside the lock region
    localparam logic [KV_ENTRY_W-1:0] OCP_LOCK_RT_OBF_KEY_KV_SLOT  = 5'd16;
    localparam logic [KV_ENTRY_W-1:0] OCP_LOCK_KEY_RELEASE_KV_SLOT = 5'd23;

    // Crypto engines that may write into the vault
    localparam int KV_NUM_WRITE       = 4;
    localparam int KV_WRITE_IDX_AES   = 0;
    localparam int KV_WRITE_IDX_HMAC  = 1;
    localparam int KV_WRITE_IDX_SHA   = 2;
    localparam int KV_WRITE_IDX_ECC   = 3;

    // A write request as an engine presents it
    // The source field is one-hot over the engines
    typedef struct packed {
        logic [KV_NUM_WRITE-1:0] kv_write_src;
        logic [KV_ENTRY_W-1:0]   kv_write_entry;
        logic                    kv_data0_present;
        logic [KV_ENTRY_W-1:0]   kv_data0_entry;
        logic                    kv_data1_present;
        logic [KV_ENTRY_W-1:0]   kv_data1_entry;
        logic                    aes_decrypt_ecb_op;
    } kv_write_req_t;

    // The same request together with the lock state, as the rule checker sees it
    typedef struct packed {
        logic                    ocp_lock_in_progress;
        logic [KV_NUM_WRITE-1:0] kv_write_src;
        logic [KV_ENTRY_W-1:0]   kv_write_entry;
        logic                    kv_data0_present;
        logic [KV_ENTRY_W-1:0]   kv_data0_entry;
        logic                    kv_data1_present;
        logic [KV_ENTRY_W-1:0]   kv_data1_entry;
        logic                    aes_decrypt_ecb_op;
    } kv_write_filter_metrics_t;

    // True when a slot index falls in the standard region
    function automatic logic kv_in_std_region(input logic [KV_ENTRY_W-1:0] entry);
        return (entry >= KV_STANDARD_SLOT_LOW) && (entry <= KV_STANDARD_SLOT_HI);
    endfunction

    // True when a slot index falls in the OCP lock region
    function automatic logic kv_in_lock_region(input logic [KV_ENTRY_W-1:0] entry);
        return (entry >= KV_OCP_LOCK_SLOT_LOW) && (entry <= KV_OCP_LOCK_SLOT_HI);
    endfunction

endpackage
